// File: verilog/biu_pkg.sv
`default_nettype none

package biu_pkg;

    typedef logic [31:0] addr_t;     // cpu byte address.
    typedef logic [31:0] data_t;     // cpu data word.
    typedef logic [12:0] txt_addr_t; // text cell index.
    typedef logic [15:0] txt_data_t; // text cell.
    typedef logic [7:0]  char_t;     // character register.
    typedef logic [3:0]  region_t;   // top address nibble.

    localparam region_t REGION_WB_DATA = 4'h3;
    localparam region_t REGION_TEXT    = 4'hb; // bit 27 picks status.
    localparam region_t REGION_WB_CHAR = 4'hc;

    // one target per cpu request.
    typedef enum logic [2:0] {
        TGT_WB_DATA,
        TGT_TEXT,
        TGT_STATUS,
        TGT_WB_CHAR,
        TGT_MIO
    } target_e;

endpackage

`default_nettype wire

// File: verilog/biu_region_decode.sv
`default_nettype none

module biu_region_decode
    import biu_pkg::*;
(
    input  addr_t   cpu_addr_i,
    output target_e target_o
);

    region_t region;

    assign region = cpu_addr_i[31:28];

    always_comb begin
        case (region)
            REGION_WB_DATA: begin
                target_o = TGT_WB_DATA;
            end
            REGION_TEXT: begin
                if (cpu_addr_i[27]) begin
                    target_o = TGT_STATUS;
                end else begin
                    target_o = TGT_TEXT;
                end
            end
            REGION_WB_CHAR: begin
                target_o = TGT_WB_CHAR;
            end
            default: begin
                target_o = TGT_MIO; // everything else goes off chip.
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/biu_target_access.sv
`default_nettype none

module biu_target_access
    import biu_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  target_e   target_i,
    input  wire       cpu_req_i,
    input  wire       cpu_we_i,
    input  addr_t     cpu_addr_i,
    input  data_t     cpu_wdata_i,
    output logic      wbd_cyc_o,
    output logic      wbd_stb_o,
    output logic      wbd_we_o,
    output logic [3:0] wbd_sel_o,
    output addr_t     wbd_adr_o,
    output data_t     wbd_dat_o,
    output logic      wbc_stb_o,
    output logic      wbc_we_o,
    output addr_t     wbc_adr_o,
    output char_t     wbc_dat_o,
    output logic      txt_en_o,
    output logic      txt_we_o,
    output txt_addr_t txt_addr_o,
    output txt_data_t txt_wdata_o,
    output logic      mio_we_o,
    output addr_t     mio_addr_o,
    output data_t     mio_wdata_o,
    output data_t     status_o
);

    logic wr_req;

    assign wr_req = cpu_req_i & cpu_we_i;

    // address and data go everywhere.
    assign wbd_adr_o   = cpu_addr_i;
    assign wbc_adr_o   = cpu_addr_i;
    assign mio_addr_o  = cpu_addr_i;
    assign txt_addr_o  = cpu_addr_i[12:0];
    assign wbd_dat_o   = cpu_wdata_i;
    assign mio_wdata_o = cpu_wdata_i;
    assign wbc_dat_o   = cpu_wdata_i[7:0];
    assign txt_wdata_o = cpu_wdata_i[15:0];
    assign wbd_sel_o   = 4'b1111; // full words only.

    always_comb begin
        wbd_cyc_o = 1'b0;
        wbd_stb_o = 1'b0;
        wbd_we_o  = 1'b0;
        wbc_stb_o = 1'b0;
        wbc_we_o  = 1'b0;
        txt_en_o  = 1'b0;
        txt_we_o  = 1'b0;
        mio_we_o  = 1'b0;
        case (target_i)
            TGT_WB_DATA: begin
                wbd_cyc_o = cpu_req_i;
                wbd_stb_o = cpu_req_i;
                wbd_we_o  = wr_req;
            end
            TGT_WB_CHAR: begin
                wbc_stb_o = cpu_req_i;
                wbc_we_o  = wr_req;
            end
            TGT_TEXT: begin
                txt_en_o = cpu_req_i;
                txt_we_o = wr_req;
            end
            TGT_MIO: begin
                mio_we_o = wr_req;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_o <= '0;
        end else if (wr_req && target_i == TGT_STATUS) begin
            status_o <= cpu_wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/biu_read_return.sv
`default_nettype none

module biu_read_return
    import biu_pkg::*;
(
    input  target_e   target_i,
    input  wire       cpu_req_i,
    input  wire       wbd_ack_i,
    input  data_t     wbd_dat_i,
    input  wire       wbc_ack_i,
    input  char_t     wbc_dat_i,
    input  txt_data_t txt_rdata_i,
    input  data_t     status_i,
    input  wire       mio_ready_i,
    input  data_t     mio_rdata_i,
    output data_t     cpu_rdata_o,
    output logic      cpu_ready_o
);

    logic done;

    always_comb begin
        case (target_i)
            TGT_WB_DATA: begin
                cpu_rdata_o = wbd_dat_i;
                done        = wbd_ack_i;
            end
            TGT_WB_CHAR: begin
                cpu_rdata_o = data_t'(wbc_dat_i);
                done        = wbc_ack_i;
            end
            TGT_TEXT: begin
                cpu_rdata_o = data_t'(txt_rdata_i);
                done        = 1'b1; // same cycle.
            end
            TGT_STATUS: begin
                cpu_rdata_o = status_i;
                done        = 1'b1;
            end
            default: begin
                cpu_rdata_o = mio_rdata_i;
                done        = mio_ready_i;
            end
        endcase
    end

    assign cpu_ready_o = cpu_req_i & done;

endmodule

`default_nettype wire

// File: verilog/text_ram.sv
`default_nettype none

module text_ram
    import biu_pkg::*;
(
    input  wire       clk,
    input  wire       en_i,
    input  wire       we_i,
    input  txt_addr_t addr_i,
    input  txt_data_t wdata_i,
    output txt_data_t rdata_o
);

    localparam int unsigned DEPTH = 2 ** $bits(txt_addr_t);

    txt_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i]; // async read.

endmodule

`default_nettype wire

// File: verilog/wb_data_ram.sv
`default_nettype none

module wb_data_ram
    import biu_pkg::*;
#(
    parameter int DRAM_WORDS = 256,
    parameter int DRAM_WAIT  = 2
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        cyc_i,
    input  wire        stb_i,
    input  wire        we_i,
    input  wire  [3:0] sel_i,
    input  addr_t      adr_i,
    input  data_t      dat_i,
    output logic       ack_o,
    output data_t      dat_o
);

    localparam int AW = $clog2(DRAM_WORDS);
    localparam int CW = $clog2(DRAM_WAIT + 2);

    data_t          mem [DRAM_WORDS];
    logic [AW-1:0]  widx;
    logic [CW-1:0]  wait_cnt;

    assign widx  = adr_i[AW+1:2]; // wraps at DRAM_WORDS.
    assign dat_o = mem[widx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o    <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_o) begin
            ack_o    <= 1'b0;
            wait_cnt <= '0;
        end else if (cyc_i && stb_i) begin
            if (int'(wait_cnt) + 1 >= DRAM_WAIT) begin
                ack_o <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DRAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ack_o && cyc_i && stb_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    mem[widx][8*b +: 8] <= dat_i[8*b +: 8]; // lane write.
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_char_regs.sv
`default_nettype none

module wb_char_regs
    import biu_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   stb_i,
    input  wire   we_i,
    input  addr_t adr_i,
    input  char_t dat_i,
    output logic  ack_o,
    output char_t dat_o
);

    char_t      regs [16];
    logic [3:0] ridx;

    assign ridx  = adr_i[3:0];
    assign dat_o = regs[ridx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o; // one cycle pulse.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ack_o && stb_i && we_i) begin
            regs[ridx] <= dat_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/biu_subsystem_top.sv
`default_nettype none

module biu_subsystem_top
    import biu_pkg::*;
#(
    parameter int DRAM_WORDS = 256,
    parameter int DRAM_WAIT  = 2
) (
    input  wire   clk,
    input  wire   rst,
    input  wire   cpu_req_i,
    input  wire   cpu_we_i,
    input  addr_t cpu_addr_i,
    input  data_t cpu_wdata_i,
    output data_t cpu_rdata_o,
    output logic  cpu_ready_o,
    output logic  mio_we_o,
    output addr_t mio_addr_o,
    output data_t mio_wdata_o,
    input  data_t mio_rdata_i,
    input  wire   mio_ready_i
);

    target_e    target;
    logic       wbd_cyc, wbd_stb, wbd_we, wbd_ack;
    logic [3:0] wbd_sel;
    addr_t      wbd_adr;
    data_t      wbd_dat_w, wbd_dat_r;
    logic       wbc_stb, wbc_we, wbc_ack;
    addr_t      wbc_adr;
    char_t      wbc_dat_w, wbc_dat_r;
    logic       txt_en, txt_we;
    txt_addr_t  txt_addr;
    txt_data_t  txt_wdata, txt_rdata;
    data_t      status;

    biu_region_decode i_decode (
        .cpu_addr_i (cpu_addr_i),
        .target_o   (target)
    );

    biu_target_access i_access (
        .clk         (clk),
        .rst         (rst),
        .target_i    (target),
        .cpu_req_i   (cpu_req_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .wbd_cyc_o   (wbd_cyc),
        .wbd_stb_o   (wbd_stb),
        .wbd_we_o    (wbd_we),
        .wbd_sel_o   (wbd_sel),
        .wbd_adr_o   (wbd_adr),
        .wbd_dat_o   (wbd_dat_w),
        .wbc_stb_o   (wbc_stb),
        .wbc_we_o    (wbc_we),
        .wbc_adr_o   (wbc_adr),
        .wbc_dat_o   (wbc_dat_w),
        .txt_en_o    (txt_en),
        .txt_we_o    (txt_we),
        .txt_addr_o  (txt_addr),
        .txt_wdata_o (txt_wdata),
        .mio_we_o    (mio_we_o),
        .mio_addr_o  (mio_addr_o),
        .mio_wdata_o (mio_wdata_o),
        .status_o    (status)
    );

    biu_read_return i_return (
        .target_i    (target),
        .cpu_req_i   (cpu_req_i),
        .wbd_ack_i   (wbd_ack),
        .wbd_dat_i   (wbd_dat_r),
        .wbc_ack_i   (wbc_ack),
        .wbc_dat_i   (wbc_dat_r),
        .txt_rdata_i (txt_rdata),
        .status_i    (status),
        .mio_ready_i (mio_ready_i),
        .mio_rdata_i (mio_rdata_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_ready_o (cpu_ready_o)
    );

    text_ram i_text_ram (
        .clk     (clk),
        .en_i    (txt_en),
        .we_i    (txt_we),
        .addr_i  (txt_addr),
        .wdata_i (txt_wdata),
        .rdata_o (txt_rdata)
    );

    wb_data_ram #(
        .DRAM_WORDS (DRAM_WORDS),
        .DRAM_WAIT  (DRAM_WAIT)
    ) i_data_ram (
        .clk   (clk),
        .rst   (rst),
        .cyc_i (wbd_cyc),
        .stb_i (wbd_stb),
        .we_i  (wbd_we),
        .sel_i (wbd_sel),
        .adr_i (wbd_adr),
        .dat_i (wbd_dat_w),
        .ack_o (wbd_ack),
        .dat_o (wbd_dat_r)
    );

    wb_char_regs i_char_regs (
        .clk   (clk),
        .rst   (rst),
        .stb_i (wbc_stb),
        .we_i  (wbc_we),
        .adr_i (wbc_adr),
        .dat_i (wbc_dat_w),
        .ack_o (wbc_ack),
        .dat_o (wbc_dat_r)
    );

endmodule

`default_nettype wire

// File: verification/biu_subsystem_asserts.sv
`default_nettype none

module biu_subsystem_asserts (
    input wire clk,
    input wire rst,
    input wire cpu_req_i,
    input wire cpu_ready_i,
    input wire wbd_cyc_i,
    input wire wbd_stb_i,
    input wire wbd_ack_i,
    input wire wbc_stb_i,
    input wire wbc_ack_i,
    input wire txt_en_i
);

    ready_needs_req: assert property (@(posedge clk) disable iff (rst)
        cpu_ready_i |-> cpu_req_i)
        else $error("cpu ready seen without a request");

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        wbd_stb_i |-> wbd_cyc_i)
        else $error("data bus strobe outside a bus cycle");

    // only the decoded target is ever strobed.
    one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wbd_stb_i, wbc_stb_i, txt_en_i}))
        else $error("more than one target strobed at once");

    wbd_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wbd_ack_i |=> !wbd_ack_i)
        else $error("data bus ack held longer than one cycle");

    wbc_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wbc_ack_i |=> !wbc_ack_i)
        else $error("char bus ack held longer than one cycle");

endmodule

`default_nettype wire

// File: verification/tb_biu_subsystem.sv
`default_nettype none

module tb_biu_subsystem
    import biu_pkg::*;
();

    localparam int DRAM_WAIT      = 2;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_TXN        = 400;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 12 + RESET_CYCLES;

    logic  clk;
    logic  rst;
    logic  cpu_req_i;
    logic  cpu_we_i;
    addr_t cpu_addr_i;
    data_t cpu_wdata_i;
    data_t cpu_rdata_o;
    logic  cpu_ready_o;
    logic  mio_we_o;
    addr_t mio_addr_o;
    data_t mio_wdata_o;
    data_t mio_rdata_i;
    logic  mio_ready_i;

    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          n_checks = 0;
    int          value_errs = 0;
    int          other_errs = 0;

    // one shadow per target for the model.
    data_t     exp_data [16];
    txt_data_t exp_txt [16];
    char_t     exp_char [16];
    data_t     exp_status;
    data_t     exp_mio [16];
    data_t     mio_mem [16]; // what the mio responder holds.

    biu_subsystem_top #(
        .DRAM_WORDS (256),
        .DRAM_WAIT  (DRAM_WAIT)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_ready_o (cpu_ready_o),
        .mio_we_o    (mio_we_o),
        .mio_addr_o  (mio_addr_o),
        .mio_wdata_o (mio_wdata_o),
        .mio_rdata_i (mio_rdata_i),
        .mio_ready_i (mio_ready_i)
    );

    bind biu_subsystem_top biu_subsystem_asserts i_asserts (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .cpu_ready_i (cpu_ready_o),
        .wbd_cyc_i   (wbd_cyc),
        .wbd_stb_i   (wbd_stb),
        .wbd_ack_i   (wbd_ack),
        .wbc_stb_i   (wbc_stb),
        .wbc_ack_i   (wbc_ack),
        .txt_en_i    (txt_en)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("the bus hangs, the run reached %0d cycles without finishing",
                     TIMEOUT_CYCLES);
            print_counts();
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]}; // one step per bit.
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, value_errs, other_errs);
    endtask

    task automatic check_rdata(input data_t exp, input data_t act);
        n_checks++;
        if (act !== exp) begin
            $display("ERROR cpu_rdata_o expected %h actual %h", exp, act);
            value_errs++;
        end
    endtask

    task automatic check_mio_addr(input addr_t exp, input addr_t act);
        n_checks++;
        if (act !== exp) begin
            $display("ERROR mio_addr_o expected %h actual %h", exp, act);
            value_errs++;
        end
    endtask

    task automatic check_mio_wdata(input data_t exp, input data_t act);
        n_checks++;
        if (act !== exp) begin
            $display("ERROR mio_wdata_o expected %h actual %h", exp, act);
            value_errs++;
        end
    endtask

    task automatic check_mio_we(input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            $display("ERROR mio_we_o expected %h actual %h", exp, act);
            value_errs++;
        end
    endtask

    task automatic do_txn(input target_e kind, input logic we, input addr_t addr,
                          input data_t wdata, input logic [3:0] idx, input int delay);
        int    n_cyc;
        logic  done;
        data_t exp;
        @(negedge clk);
        cpu_req_i   = 1'b1;
        cpu_we_i    = we;
        cpu_addr_i  = addr;
        cpu_wdata_i = wdata;
        mio_rdata_i = mio_mem[addr[5:2]];
        mio_ready_i = (kind == TGT_MIO) && (delay == 0);
        n_cyc = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            n_cyc++;
            if (cpu_ready_o) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
                mio_ready_i = (kind == TGT_MIO) && (n_cyc >= delay);
            end
        end
        // sampled at the completing edge before any register moves.
        exp = '0;
        case (kind)
            TGT_WB_DATA: begin
                if (n_cyc < DRAM_WAIT + 1) begin
                    $display("data memory was ready after only %0d cycles", n_cyc);
                    other_errs++;
                end
                exp = exp_data[idx];
                if (we) exp_data[idx] = wdata;
            end
            TGT_TEXT, TGT_STATUS: begin
                if (n_cyc != 1) begin
                    $display("text or status access took %0d cycles instead of one", n_cyc);
                    other_errs++;
                end
                exp = (kind == TGT_TEXT) ? data_t'(exp_txt[idx]) : exp_status;
                if (we && kind == TGT_TEXT) exp_txt[idx] = wdata[15:0];
                if (we && kind == TGT_STATUS) exp_status = wdata;
            end
            TGT_WB_CHAR: begin
                exp = data_t'(exp_char[idx]);
                if (we) exp_char[idx] = wdata[7:0];
            end
            default: begin
                check_mio_addr(addr, mio_addr_o);
                check_mio_wdata(wdata, mio_wdata_o);
                check_mio_we(we, mio_we_o);
                if (n_cyc != delay + 1) begin
                    $display("mio transfer ended after %0d cycles, delay was %0d", n_cyc, delay);
                    other_errs++;
                end
                exp = exp_mio[idx];
                if (we) begin
                    exp_mio[idx] = wdata;
                    mio_mem[mio_addr_o[5:2]] = mio_wdata_o; // responder stores it.
                end
            end
        endcase
        if (!we) check_rdata(exp, cpu_rdata_o);
    endtask

    initial begin
        target_e     kind;
        logic [31:0] rnd;
        logic [3:0]  idx;
        logic [3:0]  nib;
        logic [7:0]  junk;
        logic        we;
        addr_t       addr;
        data_t       wdata;
        int          delay;
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_req_i   = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        mio_rdata_i = '0;
        mio_ready_i = 1'b0;
        lfsr        = 32'd75;
        exp_status  = '0;
        for (int i = 0; i < 16; i++) begin
            exp_data[i] = '0;
            exp_txt[i]  = '0;
            exp_char[i] = '0;
            exp_mio[i]  = '0;
            mio_mem[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // write every text cell in use before any read.
        for (int i = 0; i < 16; i++) begin
            idx = 4'(i);
            take_bits(32, rnd);
            do_txn(TGT_TEXT, 1'b1, {REGION_TEXT, 24'h0, idx}, rnd, idx, 0);
        end
        for (int n = 16; n < NUM_TXN; n++) begin
            take_bits(3, rnd);
            case (rnd[2:0])
                3'd0, 3'd1: kind = TGT_WB_DATA;
                3'd2:       kind = TGT_TEXT;
                3'd3:       kind = TGT_STATUS;
                3'd4:       kind = TGT_WB_CHAR;
                default:    kind = TGT_MIO;
            endcase
            take_bits(4, rnd);
            idx = rnd[3:0];
            take_bits(8, rnd);
            junk = rnd[7:0];
            take_bits(1, rnd);
            we = rnd[0];
            take_bits(32, rnd);
            wdata = rnd;
            take_bits(3, rnd);
            delay = int'(rnd[2:0]);
            take_bits(4, rnd);
            nib = rnd[3:0];
            if (nib == REGION_WB_DATA || nib == REGION_TEXT || nib == REGION_WB_CHAR) begin
                nib = nib ^ 4'h1; // keep it off chip.
            end
            case (kind)
                TGT_WB_DATA: addr = {REGION_WB_DATA, 4'h0, junk, 10'h0, idx, 2'b00};
                TGT_TEXT:    addr = {REGION_TEXT, 4'h0, junk, 12'h0, idx};
                TGT_STATUS:  addr = {REGION_TEXT, 4'h8, junk, 12'h0, idx};
                TGT_WB_CHAR: addr = {REGION_WB_CHAR, 4'h0, junk, 12'h0, idx};
                default:     addr = {nib, 4'h0, junk, 10'h0, idx, 2'b00};
            endcase
            take_bits(1, rnd);
            if (rnd[0]) begin
                @(negedge clk);
                cpu_req_i   = 1'b0;
                mio_ready_i = 1'b0;
            end
            do_txn(kind, we, addr, wdata, idx, delay);
        end
        @(negedge clk);
        cpu_req_i   = 1'b0;
        mio_ready_i = 1'b0;
        repeat (2) @(posedge clk);
        print_counts();
        if (value_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/biu_pkg.sv
verilog/biu_region_decode.sv
verilog/biu_target_access.sv
verilog/biu_read_return.sv
verilog/text_ram.sv
verilog/wb_data_ram.sv
verilog/wb_char_regs.sv
verilog/biu_subsystem_top.sv
verification/biu_subsystem_asserts.sv
verification/tb_biu_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_biu_subsystem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "sim: no result in $(LOG)"; exit 1; fi
	@echo "sim: PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
